/* slab_alloc.f */
src/alloc_cfg_pkg.sv
src/alloc_bus_pkg.sv
src/ptr_queue.sv
src/class_queue_bank.sv
src/alloc_engine.sv
src/free_engine.sv
src/usage_stats.sv
src/slab_alloc_top.sv
testbench/tb_clock.sv
testbench/slab_alloc_assert.sv
testbench/tb_slab_alloc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_slab_alloc
FILELIST  ?= slab_alloc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_slab_alloc.sv */
`timescale 1ns/1ps

module tb_slab_alloc
    import alloc_bus_pkg::*;
();
    localparam int          BLOCK_BYTES = 64;
    localparam int          PAGE_BLOCKS = 16;
    localparam int          NUM_PAGES   = 8;
    localparam logic [31:0] DATA_BASE   = 32'h100;
    localparam logic [31:0] SEED        = 32'he9c6a8e7;
    localparam int          N_CARVE     = 20;
    // carving takes two pages and each random request at most one more
    localparam int          N_RANDOM    = NUM_PAGES - 3;
    localparam int          N_DRAIN     = 2 * NUM_PAGES + 2;
    // about 40 cycles per request at worst under back-pressure
    localparam int          MAX_CYCLES  = (N_CARVE + N_RANDOM + N_DRAIN + 4) * 40 + 200;

    logic        clk;
    logic        rst;
    alloc_req_t  req;
    logic        req_valid;
    logic        req_ready;
    alloc_resp_t resp;
    logic        malloc_valid;
    logic        malloc_ready = 1'b0;
    free_req_t   free_req;
    logic        free_valid;
    logic        free_ready;
    logic [31:0] stat_size;
    logic        back_pressure;
    alloc_resp_t resp_log [$];
    int          cycles = 0;
    int          n_sent;
    int          tb_errors;
    int          mark;
    int          tests_run;
    int          tests_failed;

    tb_clock #(.PERIOD_NS(20)) u_clock (.clk(clk));

    slab_alloc_top #(
        .BLOCK_BYTES (BLOCK_BYTES),
        .PAGE_BLOCKS (PAGE_BLOCKS),
        .NUM_PAGES   (NUM_PAGES),
        .DATA_BASE   (DATA_BASE)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .resp         (resp),
        .malloc_valid (malloc_valid),
        .malloc_ready (malloc_ready),
        .free_req     (free_req),
        .free_valid   (free_valid),
        .free_ready   (free_ready),
        .stat_size    (stat_size)
    );

    bind slab_alloc_top slab_alloc_assert #(
        .BLOCK_BYTES (BLOCK_BYTES),
        .PAGE_BLOCKS (PAGE_BLOCKS),
        .NUM_PAGES   (NUM_PAGES),
        .DATA_BASE   (DATA_BASE)
    ) u_chk (
        .clk(clk), .rst(rst), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .resp(resp), .malloc_valid(malloc_valid), .malloc_ready(malloc_ready),
        .free_req(free_req), .free_valid(free_valid), .free_ready(free_ready),
        .stat_size(stat_size)
    );

    // malloc_ready for the coming edge, and the response taken on it
    always @(negedge clk) begin
        if (!rst) begin
            malloc_ready = back_pressure ? (($urandom % 4) != 0) : 1'b1;
            if (malloc_valid && malloc_ready) begin
                resp_log.push_back(resp);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic alloc_one(input int size, output alloc_resp_t r);
        @(negedge clk);
        req.size  = 16'(size);
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        n_sent++;
        while (resp_log.size() < n_sent) @(negedge clk);
        r = resp_log[n_sent-1];
    endtask

    task automatic free_one(input logic [31:0] ptr, input int size);
        @(negedge clk);
        free_req.ptr  = ptr;
        free_req.size = 16'(size);
        free_valid    = 1'b1;
        while (!free_ready) @(negedge clk);
        @(negedge clk);
        free_valid = 1'b0;
        // free_ready comes back once the block is in its queue
        while (!free_ready) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        int found;
        found = uut.u_chk.fail_count + tb_errors - mark;
        mark  = uut.u_chk.fail_count + tb_errors;
        tests_run++;
        if (found != 0) tests_failed++;
        $display("test %0d %s: %0d failures", tests_run, name, found);
    endtask

    initial begin
        alloc_resp_t r;
        alloc_resp_t last_ok;
        int          k;
        int          waited;
        logic        seen_fail;
        void'($urandom(SEED));
        rst           = 1'b1;
        req           = '0;
        req_valid     = 1'b0;
        free_req      = '0;
        free_valid    = 1'b0;
        back_pressure = 1'b0;
        n_sent        = 0;
        tb_errors     = 0;
        mark          = 0;
        tests_run     = 0;
        tests_failed  = 0;
        last_ok       = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        waited = 0;
        while (!req_ready && waited < NUM_PAGES + 6) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            tb_errors++;
            $display("req_ready did not rise after the pages were seeded");
        end
        end_test("reset and seeding");

        for (k = 0; k < N_CARVE; k++) begin
            alloc_one(BLOCK_BYTES, r);
        end
        end_test("carving a page");

        back_pressure = 1'b1;
        for (k = 0; k < N_RANDOM; k++) begin
            alloc_one(1 + int'($urandom % (8 * BLOCK_BYTES)), r);
        end
        end_test("alignment and range");

        alloc_one(8 * BLOCK_BYTES + 88, r);
        seen_fail = 1'b0;
        k = 0;
        while (!seen_fail && k < N_DRAIN) begin
            alloc_one(8 * BLOCK_BYTES, r);
            if (r.failed) seen_fail = 1'b1;
            else last_ok = r;
            k++;
        end
        if (!seen_fail) begin
            tb_errors++;
            $display("no allocation failed after all pages were used");
        end
        end_test("failure");

        free_one(last_ok.ptr, 8 * BLOCK_BYTES);
        alloc_one(8 * BLOCK_BYTES, r);
        end_test("reuse");

        back_pressure = 1'b0;
        repeat (4) @(negedge clk);
        end_test("usage");

        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* testbench/slab_alloc_assert.sv */
`timescale 1ns/1ps

module slab_alloc_assert
    import alloc_bus_pkg::*;
#(
    parameter int          BLOCK_BYTES = 64,
    parameter int          PAGE_BLOCKS = 16,
    parameter int          NUM_PAGES   = 8,
    parameter logic [31:0] DATA_BASE   = 32'h100
) (
    input logic        clk,
    input logic        rst,
    input alloc_req_t  req,
    input logic        req_valid,
    input logic        req_ready,
    input alloc_resp_t resp,
    input logic        malloc_valid,
    input logic        malloc_ready,
    input free_req_t   free_req,
    input logic        free_valid,
    input logic        free_ready,
    input logic [31:0] stat_size
);
    logic [2:0]           cls_q [$];
    logic [2:0]           resp_cls;
    logic                 req_fire;
    logic                 resp_fire;
    logic                 free_fire;
    logic [31:0]          last1;
    logic                 chain_ok;
    logic                 chain_next;
    logic                 any_ok;
    logic [NUM_PAGES-1:0] page_mask;
    logic                 drained8;
    logic                 reuse_armed;
    logic [31:0]          reuse_ptr;
    logic [31:0]          shadow;
    logic [31:0]          shadow_d1;
    int                   n_reset;
    int                   n_stable;
    int                   n_big;
    int                   n_align;
    int                   n_chain;
    int                   n_exhaust;
    int                   n_reuse;
    int                   n_usage;
    int                   fail_count;

    // 1, 2, 4 or 8 blocks, 0 when larger than the biggest class
    function automatic logic [2:0] class_of(input logic [15:0] size);
        if (32'(size) <= 32'(BLOCK_BYTES)) return 3'd1;
        if (32'(size) <= 32'(2 * BLOCK_BYTES)) return 3'd2;
        if (32'(size) <= 32'(4 * BLOCK_BYTES)) return 3'd3;
        if (32'(size) <= 32'(8 * BLOCK_BYTES)) return 3'd4;
        return 3'd0;
    endfunction

    function automatic logic [31:0] blocks_of(input logic [2:0] cls);
        if (cls == 3'd0) return 32'd1;
        return 32'd1 << (cls - 3'd1);
    endfunction

    assign req_fire  = req_valid && req_ready;
    assign resp_fire = malloc_valid && malloc_ready;
    assign free_fire = free_valid && free_ready;

    // the carved rest of a page stays queued while two blocks follow the current one
    assign chain_next = chain_ok
                        && ((last1 - DATA_BASE) % 32'(PAGE_BLOCKS)) < 32'(PAGE_BLOCKS - 2);

    always_comb begin
        resp_cls = (cls_q.size() != 0) ? cls_q[0] : 3'd0;
        fail_count = n_reset + n_stable + n_big + n_align + n_chain + n_exhaust + n_reuse
                     + n_usage;
    end

    // ----------------------------------------------------------------------
    // shadow model of requests, responses and frees
    always_ff @(posedge clk) begin
        if (rst) begin
            cls_q.delete();
            chain_ok    <= 1'b0;
            any_ok      <= 1'b0;
            page_mask   <= '0;
            drained8    <= 1'b0;
            reuse_armed <= 1'b0;
            shadow      <= '0;
            shadow_d1   <= '0;
        end else begin
            if (req_fire) begin
                cls_q.push_back(class_of(req.size));
            end
            if (resp_fire) begin
                void'(cls_q.pop_front());
                if (!resp.failed) begin
                    any_ok   <= 1'b1;
                    chain_ok <= (resp_cls == 3'd1);
                    last1    <= resp.ptr;
                    if (resp.ptr >= DATA_BASE &&
                        (resp.ptr - DATA_BASE) / 32'(PAGE_BLOCKS) < 32'(NUM_PAGES)) begin
                        page_mask[(resp.ptr - DATA_BASE) / 32'(PAGE_BLOCKS)] <= 1'b1;
                    end
                end
                if (resp_cls == 3'd4 && resp.failed) begin
                    drained8 <= 1'b1;
                end
                if (resp_cls == 3'd4) begin
                    reuse_armed <= 1'b0;
                end
            end
            // the class-8 queue is empty here, so this block comes back next
            if (free_fire && class_of(free_req.size) == 3'd4 && drained8) begin
                reuse_armed <= 1'b1;
                reuse_ptr   <= free_req.ptr;
                drained8    <= 1'b0;
            end
            shadow <= shadow
                      + ((req_fire && class_of(req.size) != 3'd0) ? 32'(req.size) : 32'd0)
                      - ((free_fire && class_of(free_req.size) != 3'd0) ?
                         32'(free_req.size) : 32'd0);
            shadow_d1 <= shadow;
        end
    end

    // ----------------------------------------------------------------------
    a_reset: assert property (@(posedge clk) rst |=> !malloc_valid)
        else begin
            n_reset++;
            $error("ERROR %0t: malloc_valid high after reset", $time);
        end

    a_stable: assert property (@(posedge clk) disable iff (rst)
        malloc_valid && !malloc_ready |=> malloc_valid && $stable(resp))
        else begin
            n_stable++;
            $error("ERROR %0t: response changed while waiting for malloc_ready", $time);
        end

    a_big: assert property (@(posedge clk) disable iff (rst)
        resp_fire && resp_cls == 3'd0 |-> resp.failed)
        else begin
            n_big++;
            $error("ERROR %0t: oversized request returned ptr %h", $time, resp.ptr);
        end

    a_align: assert property (@(posedge clk) disable iff (rst)
        resp_fire && !resp.failed |->
            resp.ptr >= DATA_BASE
            && resp.ptr < DATA_BASE + 32'(NUM_PAGES * PAGE_BLOCKS)
            && ((resp.ptr - DATA_BASE) & (blocks_of(resp_cls) - 32'd1)) == 32'd0)
        else begin
            n_align++;
            $error("ERROR %0t: ptr %h misaligned or out of range", $time, resp.ptr);
        end

    a_chain: assert property (@(posedge clk) disable iff (rst)
        resp_fire && !resp.failed && resp_cls == 3'd1 && (chain_next || !any_ok) |->
            resp.ptr == (chain_next ? last1 + 32'd1 : DATA_BASE))
        else begin
            n_chain++;
            $error("ERROR %0t: carved ptr %h does not follow %h", $time, resp.ptr, last1);
        end

    a_exhaust: assert property (@(posedge clk) disable iff (rst)
        resp_fire && resp.failed && resp_cls != 3'd0 |-> page_mask == '1)
        else begin
            n_exhaust++;
            $error("ERROR %0t: request failed with pages %b untouched", $time, ~page_mask);
        end

    a_reuse: assert property (@(posedge clk) disable iff (rst)
        resp_fire && resp_cls == 3'd4 && reuse_armed |-> !resp.failed && resp.ptr == reuse_ptr)
        else begin
            n_reuse++;
            $error("ERROR %0t: expected freed ptr %h, got %h", $time, reuse_ptr, resp.ptr);
        end

    a_usage: assert property (@(posedge clk) disable iff (rst) stat_size == shadow_d1)
        else begin
            n_usage++;
            $error("ERROR %0t: stat_size %0d, expected %0d", $time, stat_size, shadow_d1);
        end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

/* src/slab_alloc_top.sv */
`timescale 1ns/1ps

module slab_alloc_top
    import alloc_cfg_pkg::*;
    import alloc_bus_pkg::*;
#(
    parameter int          BLOCK_BYTES      = 64,
    parameter int          PAGE_BLOCKS      = 16,
    parameter int          NUM_PAGES        = 8,
    parameter logic [31:0] DATA_BASE        = 32'h100,
    parameter int          QUEUE_DEPTH_BITS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  alloc_req_t  req,
    input  logic        req_valid,
    output logic        req_ready,
    output alloc_resp_t resp,
    output logic        malloc_valid,
    input  logic        malloc_ready,
    input  free_req_t   free_req,
    input  logic        free_valid,
    output logic        free_ready,
    output logic [31:0] stat_size
);
    logic                        seeded;
    class_idx_t                  pop_class;
    logic                        pop_en;
    ptr_desc_t [CLASS_COUNT-1:0] heads;
    logic [CLASS_COUNT-1:0]      not_empty;
    class_idx_t                  a_push_class;
    ptr_desc_t                   a_push_desc;
    logic                        a_push_valid;
    class_idx_t                  f_push_class;
    ptr_desc_t                   f_push_desc;
    logic                        f_push_valid;
    logic                        f_push_ready;
    logic                        req_fire;
    logic                        free_fire;

    assign req_fire  = req_valid && req_ready;
    assign free_fire = free_valid && free_ready;

    // ---------------------------------------------------------------------
    alloc_engine #(
        .BLOCK_BYTES (BLOCK_BYTES),
        .PAGE_BLOCKS (PAGE_BLOCKS),
        .DATA_BASE   (DATA_BASE)
    ) u_alloc (
        .clk          (clk),
        .rst          (rst),
        .seeded       (seeded),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .resp         (resp),
        .malloc_valid (malloc_valid),
        .malloc_ready (malloc_ready),
        .pop_class    (pop_class),
        .pop_en       (pop_en),
        .a_push_class (a_push_class),
        .a_push_desc  (a_push_desc),
        .a_push_valid (a_push_valid),
        .heads        (heads),
        .not_empty    (not_empty)
    );

    free_engine #(
        .BLOCK_BYTES (BLOCK_BYTES),
        .PAGE_BLOCKS (PAGE_BLOCKS),
        .NUM_PAGES   (NUM_PAGES),
        .DATA_BASE   (DATA_BASE)
    ) u_free (
        .clk          (clk),
        .rst          (rst),
        .free_req     (free_req),
        .free_valid   (free_valid),
        .free_ready   (free_ready),
        .f_push_class (f_push_class),
        .f_push_desc  (f_push_desc),
        .f_push_valid (f_push_valid),
        .f_push_ready (f_push_ready),
        .seeded       (seeded)
    );

    class_queue_bank #(
        .QUEUE_DEPTH_BITS (QUEUE_DEPTH_BITS)
    ) u_bank (
        .clk          (clk),
        .rst          (rst),
        .pop_class    (pop_class),
        .pop_en       (pop_en),
        .heads        (heads),
        .not_empty    (not_empty),
        .a_push_class (a_push_class),
        .a_push_desc  (a_push_desc),
        .a_push_valid (a_push_valid),
        .f_push_class (f_push_class),
        .f_push_desc  (f_push_desc),
        .f_push_valid (f_push_valid),
        .f_push_ready (f_push_ready)
    );

    usage_stats #(
        .BLOCK_BYTES (BLOCK_BYTES)
    ) u_stats (
        .clk       (clk),
        .rst       (rst),
        .req_size  (req.size),
        .req_fire  (req_fire),
        .free_size (free_req.size),
        .free_fire (free_fire),
        .stat_size (stat_size)
    );

endmodule

/* src/usage_stats.sv */
`timescale 1ns/1ps

module usage_stats
    import alloc_cfg_pkg::*;
#(
    parameter int BLOCK_BYTES = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] req_size,
    input  logic        req_fire,
    input  logic [15:0] free_size,
    input  logic        free_fire,
    output logic [31:0] stat_size
);
    logic [31:0] alloc_bytes;
    logic [31:0] freed_bytes;
    logic        req_counted;
    logic        free_counted;

    // sizes beyond the largest class never hold memory
    assign req_counted  = req_fire && (size_to_class(req_size, BLOCK_BYTES) != '0);
    assign free_counted = free_fire && (size_to_class(free_size, BLOCK_BYTES) != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_bytes <= '0;
            freed_bytes <= '0;
            stat_size   <= '0;
        end else begin
            if (req_counted) begin
                alloc_bytes <= alloc_bytes + 32'(req_size);
            end
            if (free_counted) begin
                freed_bytes <= freed_bytes + 32'(free_size);
            end
            stat_size <= alloc_bytes - freed_bytes;
        end
    end

endmodule

/* src/free_engine.sv */
`timescale 1ns/1ps

module free_engine
    import alloc_cfg_pkg::*;
    import alloc_bus_pkg::*;
#(
    parameter int          BLOCK_BYTES = 64,
    parameter int          PAGE_BLOCKS = 16,
    parameter int          NUM_PAGES   = 8,
    parameter logic [31:0] DATA_BASE   = 32'h100
) (
    input  logic       clk,
    input  logic       rst,
    input  free_req_t  free_req,
    input  logic       free_valid,
    output logic       free_ready,
    output class_idx_t f_push_class,
    output ptr_desc_t  f_push_desc,
    output logic       f_push_valid,
    input  logic       f_push_ready,
    output logic       seeded
);
    localparam int SEED_W = $clog2(NUM_PAGES + 1);

    typedef enum logic [1:0] {ST_SEED, ST_IDLE, ST_HOLD} state_t;

    state_t            state;
    logic [SEED_W-1:0] seed_cnt;
    class_idx_t        free_class;
    class_idx_t        hold_class;
    ptr_desc_t         seed_desc;
    ptr_desc_t         hold_desc;

    assign free_class     = size_to_class(free_req.size, BLOCK_BYTES);
    assign seed_desc.len  = 16'(PAGE_BLOCKS);
    assign seed_desc.addr = DATA_BASE + 32'(seed_cnt) * 32'(PAGE_BLOCKS);

    assign f_push_valid = (state == ST_SEED) || (state == ST_HOLD);
    assign f_push_class = (state == ST_HOLD) ? hold_class : '0;
    assign f_push_desc  = (state == ST_HOLD) ? hold_desc : seed_desc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_SEED;
            seed_cnt   <= '0;
            seeded     <= 1'b0;
            free_ready <= 1'b0;
        end else begin
            case (state)
                ST_SEED: begin
                    if (f_push_ready) begin
                        if (seed_cnt == SEED_W'(NUM_PAGES - 1)) begin
                            seeded     <= 1'b1;
                            free_ready <= 1'b1;
                            state      <= ST_IDLE;
                        end else begin
                            seed_cnt <= seed_cnt + 1'b1;
                        end
                    end
                end
                ST_IDLE: begin
                    // oversized frees are taken and dropped
                    if (free_valid && free_ready && free_class != '0) begin
                        free_ready <= 1'b0;
                        state      <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (f_push_ready) begin
                        free_ready <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && free_valid && free_ready) begin
            hold_class     <= free_class;
            hold_desc.addr <= free_req.ptr;
            hold_desc.len  <= (free_class == '0) ? 16'd0 : CLASS_BLOCKS[free_class];
        end
    end

endmodule

/* src/alloc_engine.sv */
`timescale 1ns/1ps

module alloc_engine
    import alloc_cfg_pkg::*;
    import alloc_bus_pkg::*;
#(
    parameter int          BLOCK_BYTES = 64,
    parameter int          PAGE_BLOCKS = 16,
    parameter logic [31:0] DATA_BASE   = 32'h100
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        seeded,
    input  alloc_req_t                  req,
    input  logic                        req_valid,
    output logic                        req_ready,
    output alloc_resp_t                 resp,
    output logic                        malloc_valid,
    input  logic                        malloc_ready,
    output class_idx_t                  pop_class,
    output logic                        pop_en,
    output class_idx_t                  a_push_class,
    output ptr_desc_t                   a_push_desc,
    output logic                        a_push_valid,
    input  ptr_desc_t [CLASS_COUNT-1:0] heads,
    input  logic [CLASS_COUNT-1:0]      not_empty
);
    typedef enum logic [1:0] {ST_IDLE, ST_DECIDE, ST_POP, ST_PUSH} state_t;

    state_t      state;
    logic [15:0] req_size;
    class_idx_t  dec_class;
    class_idx_t  in_class;
    class_idx_t  chosen;
    logic        fail;
    logic [15:0] units;
    ptr_desc_t   sel_head;
    ptr_desc_t   rem_desc;
    logic        sel_ok;
    logic        rem_valid;
    logic        resp_push;
    logic        resp_room;
    alloc_resp_t resp_in;

    assign dec_class = size_to_class(req_size, BLOCK_BYTES);
    assign sel_head  = heads[chosen];

    // a head outside the data region or longer than a page is dropped
    assign sel_ok = !fail && (sel_head.addr >= DATA_BASE) && (sel_head.len != 16'd0)
                    && (32'(sel_head.len) <= 32'(PAGE_BLOCKS));

    assign pop_class      = chosen;
    assign pop_en         = (state == ST_POP) && !fail;
    assign resp_push      = (state == ST_POP);
    assign resp_in.ptr    = sel_ok ? sel_head.addr : 32'd0;
    assign resp_in.failed = !sel_ok;
    assign a_push_class   = in_class;
    assign a_push_desc    = rem_desc;
    assign a_push_valid   = (state == ST_PUSH) && rem_valid;

    // ---------------------------------------------------------------------
    // request FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            req_ready <= 1'b0;
            rem_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid && req_ready) begin
                        req_ready <= 1'b0;
                        state     <= ST_DECIDE;
                    end else begin
                        req_ready <= seeded && resp_room;
                    end
                end
                ST_DECIDE: state <= ST_POP;
                ST_POP: begin
                    // keep the rest only if two more units still fit
                    rem_valid <= sel_ok && ({1'b0, sel_head.len - units} >= {units, 1'b0});
                    state     <= ST_PUSH;
                end
                ST_PUSH: begin
                    req_ready <= resp_room;
                    state     <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid && req_ready) begin
            req_size <= req.size;
        end
        if (state == ST_DECIDE) begin
            in_class <= dec_class;
            // own class first, pages as fallback
            chosen   <= (dec_class != '0 && not_empty[dec_class]) ? dec_class : '0;
            fail     <= (dec_class == '0) || (!not_empty[dec_class] && !not_empty[0]);
            units    <= (dec_class == '0) ? 16'd0 : CLASS_BLOCKS[dec_class];
        end
        if (state == ST_POP) begin
            rem_desc.len  <= sel_head.len - units;
            rem_desc.addr <= sel_head.addr + 32'(units);
        end
    end

    // ---------------------------------------------------------------------
    // response buffer, two entries
    ptr_queue #(
        .payload_t  (alloc_resp_t),
        .DEPTH_BITS (1)
    ) u_resp_buf (
        .clk        (clk),
        .rst        (rst),
        .push_valid (resp_push),
        .push_data  (resp_in),
        .push_ready (resp_room),
        .pop        (malloc_ready),
        .head       (resp),
        .not_empty  (malloc_valid)
    );

endmodule

/* src/class_queue_bank.sv */
`timescale 1ns/1ps

module class_queue_bank
    import alloc_cfg_pkg::*;
    import alloc_bus_pkg::*;
#(
    parameter int QUEUE_DEPTH_BITS = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  class_idx_t                  pop_class,
    input  logic                        pop_en,
    output ptr_desc_t [CLASS_COUNT-1:0] heads,
    output logic [CLASS_COUNT-1:0]      not_empty,
    input  class_idx_t                  a_push_class,
    input  ptr_desc_t                   a_push_desc,
    input  logic                        a_push_valid,
    input  class_idx_t                  f_push_class,
    input  ptr_desc_t                   f_push_desc,
    input  logic                        f_push_valid,
    output logic                        f_push_ready
);
    logic [CLASS_COUNT-1:0] a_sel;
    logic [CLASS_COUNT-1:0] f_sel;
    logic [CLASS_COUNT-1:0] q_push;
    logic [CLASS_COUNT-1:0] q_ready;
    logic [CLASS_COUNT-1:0] q_pop;
    ptr_desc_t              q_data [CLASS_COUNT];
    logic                   f_clash;

    // the alloc side wins when both push into the same class
    assign f_clash      = a_push_valid && (a_push_class == f_push_class);
    assign f_push_ready = (f_push_class < CLASS_COUNT) && q_ready[f_push_class] && !f_clash;

    for (genvar gv = 0; gv < CLASS_COUNT; gv++) begin : g_class
        assign a_sel[gv]  = a_push_valid && (a_push_class == class_idx_t'(gv));
        assign f_sel[gv]  = f_push_valid && (f_push_class == class_idx_t'(gv));
        assign q_push[gv] = a_sel[gv] || (f_sel[gv] && f_push_ready);
        assign q_data[gv] = a_sel[gv] ? a_push_desc : f_push_desc;
        assign q_pop[gv]  = pop_en && (pop_class == class_idx_t'(gv));

        ptr_queue #(
            .payload_t  (ptr_desc_t),
            .DEPTH_BITS (QUEUE_DEPTH_BITS)
        ) u_queue (
            .clk        (clk),
            .rst        (rst),
            .push_valid (q_push[gv]),
            .push_data  (q_data[gv]),
            .push_ready (q_ready[gv]),
            .pop        (q_pop[gv]),
            .head       (heads[gv]),
            .not_empty  (not_empty[gv])
        );
    end

endmodule

/* src/ptr_queue.sv */
`timescale 1ns/1ps

module ptr_queue #(
    parameter type payload_t  = logic [31:0],
    parameter int  DEPTH_BITS = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_valid,
    input  payload_t push_data,
    output logic     push_ready,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty
);
    localparam int DEPTH = 1 << DEPTH_BITS;

    payload_t              mem [DEPTH];
    logic [DEPTH_BITS-1:0] rd_ptr;
    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign not_empty  = (count != '0);
    assign do_pop     = pop && not_empty;
    // a pop in the same cycle frees the slot for a push when full
    assign push_ready = (count != (DEPTH_BITS + 1)'(DEPTH)) || do_pop;
    assign do_push    = push_valid && push_ready;
    assign head       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{DEPTH_BITS{1'b0}}, do_push} - {{DEPTH_BITS{1'b0}}, do_pop};
        end
    end

endmodule

/* src/alloc_bus_pkg.sv */
package alloc_bus_pkg;

    // free region: start block address and length in blocks
    typedef struct packed {
        logic [15:0] len;
        logic [31:0] addr;
    } ptr_desc_t;

    typedef struct packed {
        logic [15:0] size;
    } alloc_req_t;

    typedef struct packed {
        logic        failed;
        logic [31:0] ptr;
    } alloc_resp_t;

    // size in bytes, as given to the matching allocation
    typedef struct packed {
        logic [31:0] ptr;
        logic [15:0] size;
    } free_req_t;

endpackage

/* src/alloc_cfg_pkg.sv */
package alloc_cfg_pkg;

    // page class plus four size classes
    localparam int CLASS_COUNT = 5;

    typedef logic [2:0] class_idx_t;

    // blocks per unit of classes 1 to 4
    localparam logic [15:0] CLASS_BLOCKS [1:4] = '{16'd1, 16'd2, 16'd4, 16'd8};

    // smallest class that fits the size, 0 when the size is too large
    function automatic class_idx_t size_to_class(
        input logic [15:0] size,
        input int unsigned block_bytes
    );
        class_idx_t cls;
        cls = '0;
        for (int c = 4; c >= 1; c--) begin
            if (32'(size) <= 32'(CLASS_BLOCKS[c]) * block_bytes) begin
                cls = class_idx_t'(c);
            end
        end
        return cls;
    endfunction

endpackage
